//--- Makefile
TB_TOP := analog_top_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f sources.f --top-module $(TB_TOP) -o V$(TB_TOP)

run: build
	./obj_dir/V$(TB_TOP)

lint:
	verilator --lint-only -Wall verilog/analog_pkg.sv verilog/adc_frontend.sv \
		verilog/dac_backend.sv verilog/trigger_router.sv verilog/analog_top.sv \
		--top-module analog_top

clean:
	rm -rf obj_dir

//--- sources.f
verilog/analog_pkg.sv
verilog/adc_frontend.sv
verilog/dac_backend.sv
verilog/trigger_router.sv
verilog/analog_top.sv
tb/analog_top_tb.sv

//--- tb/analog_stim.txt
# in: adc_a adc_b asg_a asg_b pid_a pid_b loop trig mode par rdy scope_trig asg_trig
# exp: adc_a adc_b (row-2) dac_a dac_b (row-2) trig_status daisy_tx {dv,dat}
0004 0008 0000 0000 0000 0000 0 0 0 0000 0 0 0 000 000 0000 0000 0 01234
3ffc 1000 0001 0005 0002 3fff 0 0 0 0000 0 0 0 000 000 0000 0000 0 01234
2aab 1557 1000 3f00 0fff 0000 0 1 0 0000 1 1 0 002 001 3fff 3fff 4 11234
1234 3abc 1000 2000 1000 3fff 0 1 2 0000 0 1 0 400 fff 3ffb 3ffc 7 01234
0ff0 0f0f 1fff 2000 1fff 2000 0 1 6 0001 1 1 0 555 aaa 00ff 2000 5 11234
0123 3210 3ffe 0010 3fff 3ff0 0 1 1 0000 1 0 1 eaf 48d 1fff 2000 0 00000
0000 3fff 0100 0200 0000 0000 0 1 1 8000 0 1 0 3c3 3fc 1fff 2000 4 0ffff
1111 2222 2000 0000 0000 2000 0 1 0 0000 1 0 0 c84 048 3fff 0002 4 11234
3333 0444 0abc 0000 0000 0123 1 1 3 0000 1 1 0 fff 000 3dff 3eff 7 0ffff
0555 0666 3000 0000 0000 1000 1 1 7 0100 0 1 1 7ff 7ff 1fff 1fff 7 0ffff
0777 0888 0001 0002 0000 0000 1 1 7 0000 0 1 0 d50 fb7 3edc 3543 1 00000
0999 0aaa 0000 0000 0000 0000 1 0 5 0000 1 0 1 3ff bff 2fff 0fff 0 0ffff
3f00 00f0 0700 0800 0700 0800 0 1 4 ffff 1 0 1 fff fff 3ffd 3ffe 4 11234
2000 1ffc 1fff 0000 0001 0000 0 1 5 0000 1 1 0 2aa 266 3fff 3fff 0 00000
0abc 0def 0003 3ffd 0000 0000 0 0 2 0000 0 1 1 03c fc0 2fff 31ff 3 01234
0040 0080 0000 0000 0000 0000 0 0 6 0000 1 1 1 7ff 800 3fff 2000 3 11234
0000 0000 0000 0000 0000 0000 0 1 3 0010 0 0 1 37b 2af 0002 3ffc 5 00000
0000 0000 0000 0000 0000 0000 0 1 3 0000 0 1 0 020 010 3fff 3fff 3 0ffff
0000 0000 0000 0000 0000 0000 0 1 2 0000 1 0 0 000 000 3fff 3fff 5 11234
0000 0000 0000 0000 0000 0000 0 0 0 0000 0 0 0 000 000 3fff 3fff 0 01234

//--- tb/analog_top_tb.sv
// reads tb/analog_stim.txt from the project root, one row per adc_clk cycle, data checks from row 2
`timescale 1ns/1ps
`default_nettype none

module analog_top_tb;

  import analog_pkg::*;

  localparam int MAX_ROWS  = 64;  // room in the row tables
  localparam int RST_CYCLES = 5;

  //////////////////////////////////////////////////////////////////////
  // dut signals
  //////////////////////////////////////////////////////////////////////

  logic          adc_clk = 1'b0;
  logic          rst_n_i;
  adc_raw_pair_t adc_dat_i;
  adc_pair_t     adc_dat_o;
  logic          digital_loop_i;
  gen_pair_t     asg_dat_i;
  gen_pair_t     pid_dat_i;
  dac_pair_t     dac_dat_o;
  logic          dac_reset_o;
  logic          trig_i;
  daisy_mode_t   daisy_mode_i;
  logic [PAR_DW-1:0] par_dat_i;
  logic          daisy_rx_rdy_i;
  logic          scope_trig_i;
  logic          asg_trig_i;
  trig_status_t  trig_status_o;
  daisy_tx_t     daisy_tx_o;

  // one entry per stimulus row
  adc_raw_pair_t row_adc [MAX_ROWS];
  gen_pair_t     row_asg [MAX_ROWS];
  gen_pair_t     row_pid [MAX_ROWS];
  logic          row_loop [MAX_ROWS];
  logic          row_trig [MAX_ROWS];
  daisy_mode_t   row_mode [MAX_ROWS];
  logic [PAR_DW-1:0] row_par [MAX_ROWS];
  logic          row_rdy [MAX_ROWS];
  logic          row_strig [MAX_ROWS];
  logic          row_atrig [MAX_ROWS];
  adc_pair_t     exp_adc [MAX_ROWS];   // result of row-2 inputs
  dac_pair_t     exp_dac [MAX_ROWS];   // result of row-2 inputs
  trig_status_t  exp_trig [MAX_ROWS];  // same cycle
  daisy_tx_t     exp_daisy [MAX_ROWS]; // same cycle

  int n_rows      = 0;
  int cycle_cnt   = 0;
  int cycle_limit = MAX_ROWS + 20;  // tightened once the file is read

  analog_top u_analog_top (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .adc_dat_o      (adc_dat_o),
    .digital_loop_i (digital_loop_i),
    .asg_dat_i      (asg_dat_i),
    .pid_dat_i      (pid_dat_i),
    .dac_dat_o      (dac_dat_o),
    .dac_reset_o    (dac_reset_o),
    .trig_i         (trig_i),
    .daisy_mode_i   (daisy_mode_i),
    .par_dat_i      (par_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .trig_status_o  (trig_status_o),
    .daisy_tx_o     (daisy_tx_o)
  );

  always #10 adc_clk = ~adc_clk;  // 20 ns period

  //////////////////////////////////////////////////////////////////////
  // failure reporting and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(input string why);
    $display("test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_adc(input string name, input adc_pair_t exp_v, input adc_pair_t act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s expected %h actual %h", name, exp_v, act_v);
      stop_on_error("adc sample mismatch");
    end
  endtask

  task automatic check_dac(input string name, input dac_pair_t exp_v, input dac_pair_t act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s expected %h actual %h", name, exp_v, act_v);
      stop_on_error("dac code mismatch");
    end
  endtask

  task automatic check_trig(input string name, input trig_status_t exp_v,
                            input trig_status_t act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s expected %h actual %h", name, exp_v, act_v);
      stop_on_error("trigger status mismatch");
    end
  endtask

  task automatic check_daisy(input string name, input daisy_tx_t exp_v, input daisy_tx_t act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s expected %h actual %h", name, exp_v, act_v);
      stop_on_error("daisy word mismatch");
    end
  endtask

  task automatic check_reset(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
      $display("Mismatch %s expected %b actual %b", name, exp_v, act_v);
      stop_on_error("dac reset mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // stimulus file
  //////////////////////////////////////////////////////////////////////

  task automatic load_rows();
    int    fd;
    int    cnt;
    string line;
    logic [DAC_DW-1:0] f_aa, f_ab, f_ga, f_gb, f_pa, f_pb;
    logic [DAC_DW-1:0] f_da, f_db;
    logic [ADC_SMP_W-1:0] f_sa, f_sb;
    logic [2:0]  f_mode, f_trig;
    logic [PAR_DW-1:0] f_par;
    logic [PAR_DW:0] f_dz;
    logic f_loop, f_t, f_rdy, f_st, f_at;
    fd = $fopen("tb/analog_stim.txt", "r");
    if (fd == 0) begin
      stop_on_error("cannot open tb/analog_stim.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // skip comments and blank lines
      if (line.len() < 2 || line.getc(0) == 8'h23) begin
        continue;
      end
      if (n_rows >= MAX_ROWS) begin
        stop_on_error("stimulus file has more rows than the tables hold");
      end
      cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f_aa, f_ab, f_ga, f_gb, f_pa, f_pb, f_loop, f_t, f_mode, f_par,
                    f_rdy, f_st, f_at, f_sa, f_sb, f_da, f_db, f_trig, f_dz);
      if (cnt != 19) begin
        stop_on_error("malformed row in stimulus file");
      end
      row_adc[n_rows]   = '{a: f_aa, b: f_ab};
      row_asg[n_rows]   = '{a: f_ga, b: f_gb};
      row_pid[n_rows]   = '{a: f_pa, b: f_pb};
      row_loop[n_rows]  = f_loop;
      row_trig[n_rows]  = f_t;
      row_mode[n_rows]  = daisy_mode_t'(f_mode);
      row_par[n_rows]   = f_par;
      row_rdy[n_rows]   = f_rdy;
      row_strig[n_rows] = f_st;
      row_atrig[n_rows] = f_at;
      exp_adc[n_rows]   = '{a: f_sa, b: f_sb};
      exp_dac[n_rows]   = '{a: f_da, b: f_db};
      exp_trig[n_rows]  = trig_status_t'(f_trig);
      exp_daisy[n_rows] = daisy_tx_t'(f_dz);
      n_rows++;
    end
    $fclose(fd);
    if (n_rows < 3) begin
      stop_on_error("stimulus file holds too few rows");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // timeout
  //////////////////////////////////////////////////////////////////////

  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      stop_on_error("timeout, run did not finish within the cycle limit");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    string tag;
    rst_n_i        = 1'b0;
    adc_dat_i      = '0;
    digital_loop_i = 1'b0;
    asg_dat_i      = '0;
    pid_dat_i      = '0;
    trig_i         = 1'b0;
    daisy_mode_i   = '0;
    par_dat_i      = '0;
    daisy_rx_rdy_i = 1'b0;
    scope_trig_i   = 1'b0;
    asg_trig_i     = 1'b0;

    load_rows();
    cycle_limit = n_rows + 20;  // reset fits inside the margin

    // dac reset stays high the whole time
    repeat (RST_CYCLES) begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      check_reset("reset dac_reset_o", 1'b1, dac_reset_o);
    end

    for (int i = 0; i < n_rows; i++) begin
      @(posedge adc_clk);
      rst_n_i        <= 1'b1;  // released together with row 0
      adc_dat_i      <= row_adc[i];
      asg_dat_i      <= row_asg[i];
      pid_dat_i      <= row_pid[i];
      digital_loop_i <= row_loop[i];
      trig_i         <= row_trig[i];
      daisy_mode_i   <= row_mode[i];
      par_dat_i      <= row_par[i];
      daisy_rx_rdy_i <= row_rdy[i];
      scope_trig_i   <= row_strig[i];
      asg_trig_i     <= row_atrig[i];
      @(negedge adc_clk);  // outputs settled mid cycle
      if (i == 0) begin
        // release not yet sampled by the dut
        check_reset("row 0 dac_reset_o", 1'b1, dac_reset_o);
      end else begin
        check_reset($sformatf("row %0d dac_reset_o", i), 1'b0, dac_reset_o);
      end
      if (i >= 2) begin
        tag = $sformatf("row %0d", i);
        check_adc({tag, " adc_dat_o"}, exp_adc[i], adc_dat_o);
        check_dac({tag, " dac_dat_o"}, exp_dac[i], dac_dat_o);
        check_trig({tag, " trig_status_o"}, exp_trig[i], trig_status_o);
        check_daisy({tag, " daisy_tx_o"}, exp_daisy[i], daisy_tx_o);
      end
    end

    $display("test passed");
    $finish;
  end

endmodule : analog_top_tb

`default_nettype wire

//--- verilog/adc_frontend.sv
// adc words arrive deserialized and aligned to adc_clk, output lags the pins by two cycles
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,        // sync, active low
  input  analog_pkg::adc_raw_pair_t adc_dat_i,      // raw words from the adc
  input  analog_pkg::dac_pair_t     dac_code_i,     // registered dac code for loopback
  input  logic                      digital_loop_i, // 1 selects dac code instead of adc
  output analog_pkg::adc_pair_t     adc_dat_o       // samples to acquisition
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // stage 1 capture
  //////////////////////////////////////////////////////////////////////

  adc_raw_pair_t adc_raw_q;  // first register behind the pins

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_raw_q <= '0;
    end else begin
      adc_raw_q <= adc_dat_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2 swap, truncate and loopback
  //////////////////////////////////////////////////////////////////////

  // top bits of each word with the low two dropped
  adc_smp_t adc_top_a;
  adc_smp_t adc_top_b;
  adc_smp_t loop_top_a;
  adc_smp_t loop_top_b;
  adc_pair_t sw_nxt;  // what the switch register loads next

  assign adc_top_a  = adc_raw_q.a[ADC_DW-1 -: ADC_SMP_W];
  assign adc_top_b  = adc_raw_q.b[ADC_DW-1 -: ADC_SMP_W];
  assign loop_top_a = dac_code_i.a[DAC_DW-1 -: ADC_SMP_W];  // dac code, same scale
  assign loop_top_b = dac_code_i.b[DAC_DW-1 -: ADC_SMP_W];

  always_comb begin
    if (digital_loop_i) begin
      // loopback keeps channel order
      sw_nxt.a = loop_top_a;
      sw_nxt.b = loop_top_b;
    end else begin
      // board routes adc b to channel a and vice versa
      sw_nxt.a = adc_top_b;
      sw_nxt.b = adc_top_a;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      adc_dat_o <= '0;
    end else begin
      adc_dat_o <= sw_nxt;  // second cycle of latency
    end
  end

endmodule : adc_frontend

`default_nettype wire

//--- verilog/analog_pkg.sv
// assumes a two channel board with 14 bit adc and dac words and a 16 bit daisy parallel word
`default_nettype none

package analog_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned ADC_DW    = 14;  // raw adc word
  localparam int unsigned ADC_SMP_W = 12;  // sample handed to acquisition
  localparam int unsigned DAC_DW    = 14;  // dac and generator word
  localparam int unsigned PAR_DW    = 16;  // daisy parallel side

  localparam logic [PAR_DW-1:0] DAISY_IDLE_WORD = 16'h1234;  // sent outside sync mode

  //////////////////////////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////////////////////////

  typedef logic        [ADC_DW-1:0]    adc_raw_t;   // unsigned, straight from the pins
  typedef logic        [ADC_SMP_W-1:0] adc_smp_t;   // top bits only
  typedef logic signed [DAC_DW-1:0]    gen_smp_t;   // asg or pid output, two's complement
  typedef logic        [DAC_DW-1:0]    dac_code_t;  // inverted code the dac expects
  typedef logic signed [DAC_DW:0]      dac_sum_t;   // one guard bit for overflow detect

  // channel pairs with a in the upper half
  typedef struct packed {
    adc_raw_t a;
    adc_raw_t b;
  } adc_raw_pair_t;

  typedef struct packed {
    adc_smp_t a;
    adc_smp_t b;
  } adc_pair_t;

  typedef struct packed {
    gen_smp_t a;
    gen_smp_t b;
  } gen_pair_t;

  typedef struct packed {
    dac_code_t a;
    dac_code_t b;
  } dac_pair_t;

  //////////////////////////////////////////////////////////////////////
  // trigger and daisy
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    TRIG_SRC_SCOPE = 1'b0,  // scope trigger out
    TRIG_SRC_ASG   = 1'b1   // generator trigger out
  } trig_src_e;

  // packs to 3 bits as {src, exp_en, sync}
  typedef struct packed {
    trig_src_e trig_src;     // [2]
    logic      exp_trig_en;  // [1] drive trigger onto expansion pin
    logic      sync_mode;    // [0] daisy link carries the trigger
  } daisy_mode_t;

  typedef struct packed {
    logic trig_ext;     // to scope and asg
    logic exp_trig;     // expansion pin data
    logic exp_trig_oe;  // expansion pin output enable
  } trig_status_t;

  typedef struct packed {
    logic              dv;   // parallel word valid
    logic [PAR_DW-1:0] dat;  // parallel word to serializer
  } daisy_tx_t;

endpackage : analog_pkg

`default_nettype wire

//--- verilog/analog_top.sv
// covers only the adc_clk domain of the board with rst_n_i standing in for pll lock and delay ready
`timescale 1ns/1ps
`default_nettype none

module analog_top (
  input  logic                      adc_clk,
  input  logic                      rst_n_i,        // sync, active low
  // adc
  input  analog_pkg::adc_raw_pair_t adc_dat_i,      // parallel adc words
  output analog_pkg::adc_pair_t     adc_dat_o,      // to acquisition
  input  logic                      digital_loop_i, // dac code back into acquisition
  // dac
  input  analog_pkg::gen_pair_t     asg_dat_i,      // generator samples
  input  analog_pkg::gen_pair_t     pid_dat_i,      // controller samples
  output analog_pkg::dac_pair_t     dac_dat_o,      // dac pins
  output logic                      dac_reset_o,
  // triggers and daisy
  input  logic                      trig_i,
  input  analog_pkg::daisy_mode_t   daisy_mode_i,
  input  logic [analog_pkg::PAR_DW-1:0] par_dat_i,  // daisy receive word
  input  logic                      daisy_rx_rdy_i,
  input  logic                      scope_trig_i,
  input  logic                      asg_trig_i,
  output analog_pkg::trig_status_t  trig_status_o,
  output analog_pkg::daisy_tx_t     daisy_tx_o
);

  import analog_pkg::*;

  dac_pair_t dac_code;  // unswapped dac code, feeds loopback

  //////////////////////////////////////////////////////////////////////
  // adc receive path
  //////////////////////////////////////////////////////////////////////

  adc_frontend u_adc_frontend (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_dat_i      (adc_dat_i),
    .dac_code_i     (dac_code),        // loopback keeps a on a
    .digital_loop_i (digital_loop_i),
    .adc_dat_o      (adc_dat_o)
  );

  //////////////////////////////////////////////////////////////////////
  // dac transmit path
  //////////////////////////////////////////////////////////////////////

  dac_backend u_dac_backend (
    .adc_clk     (adc_clk),
    .rst_n_i     (rst_n_i),
    .asg_dat_i   (asg_dat_i),
    .pid_dat_i   (pid_dat_i),
    .dac_code_o  (dac_code),
    .dac_dat_o   (dac_dat_o),
    .dac_reset_o (dac_reset_o)
  );

  //////////////////////////////////////////////////////////////////////
  // trigger routing
  //////////////////////////////////////////////////////////////////////

  trigger_router u_trigger_router (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .trig_i         (trig_i),
    .daisy_mode_i   (daisy_mode_i),
    .par_dat_i      (par_dat_i),
    .daisy_rx_rdy_i (daisy_rx_rdy_i),
    .scope_trig_i   (scope_trig_i),
    .asg_trig_i     (asg_trig_i),
    .trig_status_o  (trig_status_o),
    .daisy_tx_o     (daisy_tx_o)
  );

endmodule : analog_top

`default_nettype wire

//--- verilog/dac_backend.sv
// asg and pid samples are two's complement, the dac takes an inverted code with channels crossed
`timescale 1ns/1ps
`default_nettype none

module dac_backend (
  input  logic                  adc_clk,
  input  logic                  rst_n_i,     // sync, active low
  input  analog_pkg::gen_pair_t asg_dat_i,   // arbitrary generator samples
  input  analog_pkg::gen_pair_t pid_dat_i,   // controller samples
  output analog_pkg::dac_pair_t dac_code_o,  // code before the swap, also loopback source
  output analog_pkg::dac_pair_t dac_dat_o,   // to the dac pins
  output logic                  dac_reset_o  // dac reset, active high
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // sum and saturate
  //////////////////////////////////////////////////////////////////////

  // add at 15 bits, clip, then invert for the dac
  // pos overflow gives 2000 (inverse of 1fff), neg overflow gives 1fff
  function automatic dac_code_t sat_inv(input gen_smp_t asg_smp, input gen_smp_t pid_smp);
    dac_sum_t sum;
    logic     ovf;
    sum = dac_sum_t'(asg_smp) + dac_sum_t'(pid_smp);
    ovf = sum[DAC_DW] ^ sum[DAC_DW-1];  // guard bit and msb disagree
    if (ovf) begin
      sat_inv = {~sum[DAC_DW], {(DAC_DW-1){sum[DAC_DW]}}};  // inverted limit
    end else begin
      sat_inv = ~sum[DAC_DW-1:0];  // in range so plain invert
    end
  endfunction

  dac_pair_t dac_code_nxt;

  assign dac_code_nxt.a = sat_inv(asg_dat_i.a, pid_dat_i.a);
  assign dac_code_nxt.b = sat_inv(asg_dat_i.b, pid_dat_i.b);

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      dac_code_o <= '0;
      dac_dat_o  <= '0;
    end else begin
      dac_code_o <= dac_code_nxt;  // 1 cycle after the inputs
      // crossed on the board, so ch b drives dac a
      dac_dat_o.a <= dac_code_o.b;
      dac_dat_o.b <= dac_code_o.a;  // 2 cycles after the inputs
    end
  end

  // high through reset, drops on the first edge after release
  always_ff @(posedge adc_clk) begin
    dac_reset_o <= ~rst_n_i;
  end

endmodule : dac_backend

`default_nettype wire

//--- verilog/trigger_router.sv
// the daisy link is seen from its parallel side only and the expansion pin as data plus output enable
`timescale 1ns/1ps
`default_nettype none

module trigger_router (
  input  logic                     adc_clk,
  input  logic                     rst_n_i,        // sync, active low
  input  logic                     trig_i,         // external trigger pin
  input  analog_pkg::daisy_mode_t  daisy_mode_i,   // trigger routing config
  input  logic [analog_pkg::PAR_DW-1:0] par_dat_i, // daisy receive word
  input  logic                     daisy_rx_rdy_i, // receiver ready
  input  logic                     scope_trig_i,   // scope trigger out
  input  logic                     asg_trig_i,     // generator trigger out
  output analog_pkg::trig_status_t trig_status_o,
  output analog_pkg::daisy_tx_t    daisy_tx_o      // daisy transmit word
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // daisy trigger detect
  //////////////////////////////////////////////////////////////////////

  logic daisy_trig;  // any bit set on the incoming word

  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      daisy_trig <= 1'b0;
    end else begin
      daisy_trig <= |par_dat_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // source select and expansion pin
  //////////////////////////////////////////////////////////////////////

  logic trig_sel;  // trigger chosen for export

  assign trig_sel = (daisy_mode_i.trig_src == TRIG_SRC_ASG) ? asg_trig_i : scope_trig_i;

  // in sync mode a daisy trigger masks the local pin
  assign trig_status_o.trig_ext    = trig_i & ~(daisy_mode_i.sync_mode & daisy_trig);
  assign trig_status_o.exp_trig    = trig_sel & daisy_mode_i.exp_trig_en;
  assign trig_status_o.exp_trig_oe = daisy_mode_i.exp_trig_en;  // pin drives only when enabled

  //////////////////////////////////////////////////////////////////////
  // daisy transmit word
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    if (daisy_mode_i.sync_mode) begin
      // trigger copied into every bit, receiver ors them back
      daisy_tx_o.dat = {PAR_DW{trig_sel}};
      daisy_tx_o.dv  = 1'b0;
    end else begin
      daisy_tx_o.dat = DAISY_IDLE_WORD;  // fixed test pattern
      daisy_tx_o.dv  = daisy_rx_rdy_i;
    end
  end

endmodule : trigger_router

`default_nettype wire
